//--- Bender.yml
package:
  name: bec_ctrl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/bec_field_pkg.sv
      - hdl/bec_ctrl_pkg.sv
      - hdl/bec_cmd_decode.sv
      - hdl/bec_operand_bank.sv
      - hdl/bec_sequencer.sv
      - hdl/bec_result_store.sv
      - hdl/bec_ctrl_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/bec_ctrl_sva.sv
      - tb/bec_ctrl_tb.sv

//--- bec_ctrl.f
+incdir+hdl
hdl/bec_field_pkg.sv
hdl/bec_ctrl_pkg.sv
hdl/bec_cmd_decode.sv
hdl/bec_operand_bank.sv
hdl/bec_sequencer.sv
hdl/bec_result_store.sv
hdl/bec_ctrl_top.sv
tb/bec_ctrl_sva.sv
tb/bec_ctrl_tb.sv

//--- hdl/bec_cmd_decode.sv
`timescale 1ns/10ps
`include "bec_consts.svh"

module bec_cmd_decode (
	input bec_field_pkg::word_t la_data_in,
	output bec_ctrl_pkg::cmd_t cmd
);
	import bec_field_pkg::*;

	logic [2:0] op_bits;
	logic [2:0] chunk_bits;
	logic is_enter;
	logic is_start;
	logic addr_shape;

	assign op_bits = la_data_in[31:29];
	assign chunk_bits = la_data_in[28:26];

	assign is_enter = (la_data_in[31:16] == `BEC_CMD_ENTER);
	assign is_start = (la_data_in[31:16] == `BEC_CMD_START);

	// Read address is 0x000N0000
	assign addr_shape = (la_data_in[31:20] == 12'h000) && (la_data_in[15:0] == 16'h0000);

	always_comb begin
		cmd.enter = is_enter;
		cmd.start = is_start;
		cmd.finish = (la_data_in == `BEC_CMD_FINISH);

		// Operand 7 and chunk 7 are unused codes
		cmd.load_chunk = (op_bits != 3'd7) && (chunk_bits != 3'd7) && !is_enter && !is_start;
		cmd.operand = operand_e'(op_bits);
		cmd.chunk = chunk_bits;
		cmd.payload = la_data_in[`BEC_CHUNK_W-1:0];

		cmd.read_index = la_data_in[19:16];
		cmd.read_sel = addr_shape &&
			(la_data_in[19:16] < 4'(`BEC_COLLECT_SLOTS));
	end

endmodule

//--- hdl/bec_consts.svh
`ifndef BEC_CONSTS_SVH
`define BEC_CONSTS_SVH

// Data widths
`define BEC_FIELD_W 163
`define BEC_WORD_W 32
`define BEC_CHUNK_W 26

// Run counter width in cycles
`define BEC_CNT_W 18

// Six coordinates of eight word slots each
`define BEC_LOAD_SLOTS 48

// wout then zout, six words each
`define BEC_COLLECT_SLOTS 12

// Host command codes
`define BEC_CMD_ENTER 16'hAB30
`define BEC_CMD_START 16'hEF41
`define BEC_CMD_FINISH 32'hAB500000

// Host status words
`define BEC_BUSY_WORD 32'hBC000000
`define BEC_STATUS_BASE 32'hC8000000

`endif

//--- hdl/bec_ctrl_pkg.sv
`include "bec_consts.svh"

package bec_ctrl_pkg;

	typedef enum logic [2:0] {
		IDLE,
		WRITE,
		LOAD,
		EXEC,
		COLLECT,
		READ
	} seq_state_e;

	// Host word after decode, not yet qualified by state
	typedef struct packed {
		logic enter;
		logic start;
		logic finish;
		logic load_chunk;
		logic read_sel;
		bec_field_pkg::operand_e operand;
		logic [2:0] chunk;
		logic [`BEC_CHUNK_W-1:0] payload;
		logic [3:0] read_index;
	} cmd_t;

	// Sequencer view shared by the bank and the result store
	typedef struct packed {
		seq_state_e state;
		logic load_we;
		logic commit;
		bec_field_pkg::slot_t slot;
		logic collecting;
		logic exec;
	} seq_ctrl_t;

endpackage

//--- hdl/bec_ctrl_top.sv
`timescale 1ns/10ps

module bec_ctrl_top (
	input logic clk,
	input logic rst,
	input bec_field_pkg::word_t la_data_in,
	input logic next_key,
	input logic slv_done,
	input bec_field_pkg::word_t data_in,
	output bec_field_pkg::word_t la_data_out,
	output logic slv_enable,
	output logic load_data,
	output bec_field_pkg::slot_t load_status,
	output bec_field_pkg::word_t data_out,
	output logic ki
);
	import bec_ctrl_pkg::*;

	cmd_t cmd;
	seq_ctrl_t ctrl;

	bec_cmd_decode u_decode (
		.la_data_in(la_data_in),
		.cmd(cmd)
	);

	bec_sequencer u_seq (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.slv_done(slv_done),
		.ctrl(ctrl),
		.slv_enable(slv_enable),
		.load_data(load_data),
		.load_status(load_status)
	);

	// Operand staging and coordinate streaming
	bec_operand_bank u_bank (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.ctrl(ctrl),
		.next_key(next_key),
		.data_out(data_out),
		.ki(ki)
	);

	bec_result_store u_result (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.ctrl(ctrl),
		.slv_done(slv_done),
		.data_in(data_in),
		.la_data_out(la_data_out)
	);

endmodule

//--- hdl/bec_field_pkg.sv
`include "bec_consts.svh"

package bec_field_pkg;

	// One GF(2^163) element, operand or result
	typedef logic [`BEC_FIELD_W-1:0] field_t;

	typedef logic [`BEC_WORD_W-1:0] word_t;

	// Operand index as carried in bits 31:29 of a load word
	typedef enum logic [2:0] {
		op_w1 = 3'd0,
		op_z1 = 3'd1,
		op_w2 = 3'd2,
		op_z2 = 3'd3,
		op_inv_w0 = 3'd4,
		op_d = 3'd5,
		op_key = 3'd6
	} operand_e;

	typedef logic [5:0] slot_t;

	typedef logic [`BEC_CNT_W-1:0] run_count_t;

endpackage

//--- hdl/bec_operand_bank.sv
`timescale 1ns/10ps
`include "bec_consts.svh"

module bec_operand_bank (
	input logic clk,
	input logic rst,
	input bec_ctrl_pkg::cmd_t cmd,
	input bec_ctrl_pkg::seq_ctrl_t ctrl,
	input logic next_key,
	output bec_field_pkg::word_t data_out,
	output logic ki
);
	import bec_field_pkg::*;
	import bec_ctrl_pkg::*;

	// Coordinates are sent as six 32-bit words
	localparam int ext_w = 6 * `BEC_WORD_W;

	field_t stage_q [7];
	field_t coord_q [6];
	field_t key_q;
	logic [7:0] chunk_hi;
	logic [ext_w-1:0] coord_ext;

	// Top bit of the piece addressed by a load chunk
	assign chunk_hi = 8'(`BEC_FIELD_W - 1 - `BEC_CHUNK_W * int'(cmd.chunk));

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 7; i++) begin
				stage_q[i] <= '0;
			end
		end else if (ctrl.load_we) begin
			if (cmd.chunk == 3'd6) begin
				stage_q[cmd.operand][6:0] <= cmd.payload[6:0];
			end else begin
				stage_q[cmd.operand][chunk_hi -: `BEC_CHUNK_W] <= cmd.payload;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 6; i++) begin
				coord_q[i] <= '0;
			end
			key_q <= '0;
		end else if (ctrl.commit) begin
			for (int i = 0; i < 6; i++) begin
				coord_q[i] <= stage_q[i];
			end
			key_q <= stage_q[op_key];
		end else if (ctrl.exec && next_key) begin
			// Rotate right so the next scalar bit lands in bit 0
			key_q <= {key_q[0], key_q[`BEC_FIELD_W-1:1]};
		end
	end

	assign ki = ctrl.exec ? key_q[0] : 1'b0;

	// Slot picks operand in bits 5:3 and word in bits 2:0
	always_comb begin
		coord_ext = '0;
		data_out = '0;
		if ((ctrl.state == LOAD) && (ctrl.slot[2:0] < 3'd6)) begin
			coord_ext = ext_w'(coord_q[ctrl.slot[5:3]]);
			data_out = coord_ext[`BEC_WORD_W * ctrl.slot[2:0] +: `BEC_WORD_W];
		end
	end

endmodule

//--- hdl/bec_result_store.sv
`timescale 1ns/10ps
`include "bec_consts.svh"

module bec_result_store (
	input logic clk,
	input logic rst,
	input bec_ctrl_pkg::cmd_t cmd,
	input bec_ctrl_pkg::seq_ctrl_t ctrl,
	input logic slv_done,
	input bec_field_pkg::word_t data_in,
	output bec_field_pkg::word_t la_data_out
);
	import bec_field_pkg::*;
	import bec_ctrl_pkg::*;

	localparam int rd_chunk_w = 28;
	localparam int top_lsb = 5 * `BEC_WORD_W;

	field_t wout_q;
	field_t zout_q;
	run_count_t run_cnt;
	logic [2:0] cap_word;
	logic [2:0] rd_word;
	field_t rd_field;
	logic [rd_chunk_w-1:0] rd_chunk;

	// Slots 0 to 5 carry wout, slots 6 to 11 carry zout
	assign cap_word = (ctrl.slot < 6'd6) ? ctrl.slot[2:0] : 3'(ctrl.slot - 6'd6);

	always_ff @(posedge clk) begin
		if (rst) begin
			wout_q <= '0;
			zout_q <= '0;
		end else if (ctrl.collecting) begin
			if (ctrl.slot < 6'd6) begin
				if (cap_word == 3'd5) begin
					wout_q[`BEC_FIELD_W-1:top_lsb] <= data_in[`BEC_FIELD_W-top_lsb-1:0];
				end else begin
					wout_q[`BEC_WORD_W * cap_word +: `BEC_WORD_W] <= data_in;
				end
			end else if (cap_word == 3'd5) begin
				zout_q[`BEC_FIELD_W-1:top_lsb] <= data_in[`BEC_FIELD_W-top_lsb-1:0];
			end else begin
				zout_q[`BEC_WORD_W * cap_word +: `BEC_WORD_W] <= data_in;
			end
		end
	end

	// Busy cycles of the coprocessor in the current run
	always_ff @(posedge clk) begin
		if (rst || ctrl.commit) begin
			run_cnt <= '0;
		end else if (ctrl.exec && !slv_done) begin
			run_cnt <= run_cnt + 1'b1;
		end
	end

	// 28-bit readback chunks from the top, the last one zero padded
	always_comb begin
		rd_word = (cmd.read_index < 4'd6) ? cmd.read_index[2:0] : 3'(cmd.read_index - 4'd6);
		rd_field = (cmd.read_index < 4'd6) ? wout_q : zout_q;
		if (rd_word == 3'd5) begin
			rd_chunk = {5'b0, rd_field[22:0]};
		end else begin
			rd_chunk = rd_field[`BEC_FIELD_W - 1 - rd_chunk_w * rd_word -: rd_chunk_w];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			la_data_out <= '0;
		end else begin
			case (ctrl.state)
				IDLE: la_data_out <= '0;
				// Busy shows up together with load_data
				WRITE: la_data_out <= ctrl.commit ? `BEC_BUSY_WORD : '0;
				READ: begin
					if (cmd.read_sel) begin
						la_data_out <= {cmd.read_index + 4'd1, rd_chunk};
					end else if (cmd.finish) begin
						la_data_out <= `BEC_STATUS_BASE ^ word_t'(run_cnt);
					end
				end
				default: la_data_out <= `BEC_BUSY_WORD;
			endcase
		end
	end

endmodule

//--- hdl/bec_sequencer.sv
`timescale 1ns/10ps
`include "bec_consts.svh"

module bec_sequencer (
	input logic clk,
	input logic rst,
	input bec_ctrl_pkg::cmd_t cmd,
	input logic slv_done,
	output bec_ctrl_pkg::seq_ctrl_t ctrl,
	output logic slv_enable,
	output logic load_data,
	output bec_field_pkg::slot_t load_status
);
	import bec_field_pkg::*;
	import bec_ctrl_pkg::*;

	localparam slot_t last_load_slot = slot_t'(`BEC_LOAD_SLOTS - 1);
	localparam slot_t last_collect_slot = slot_t'(`BEC_COLLECT_SLOTS - 1);

	seq_state_e state;
	seq_state_e state_nxt;
	slot_t slot;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (cmd.enter) begin
					state_nxt = WRITE;
				end
			end
			WRITE: begin
				if (cmd.start) begin
					state_nxt = LOAD;
				end
			end
			LOAD: begin
				if (slot == last_load_slot) begin
					state_nxt = EXEC;
				end
			end
			EXEC: begin
				// Run length is set by the coprocessor
				if (slv_done) begin
					state_nxt = COLLECT;
				end
			end
			COLLECT: begin
				if (slot == last_collect_slot) begin
					state_nxt = READ;
				end
			end
			READ: begin
				if (cmd.finish) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			slot <= '0;
		end else begin
			state <= state_nxt;
			// Each phase starts counting from slot 0
			if (state_nxt != state) begin
				slot <= '0;
			end else if ((state == LOAD) || (state == COLLECT)) begin
				slot <= slot + 1'b1;
			end
		end
	end

	always_comb begin
		ctrl.state = state;
		ctrl.load_we = cmd.load_chunk && (state == WRITE);
		ctrl.commit = cmd.start && (state == WRITE);
		ctrl.slot = slot;
		ctrl.collecting = (state == COLLECT);
		ctrl.exec = (state == EXEC);
	end

	assign load_data = (state == LOAD);
	assign slv_enable = (state == EXEC);
	assign load_status = slot;

endmodule

//--- tb/bec_ctrl_sva.sv
`timescale 1ns/10ps
`include "bec_consts.svh"

module bec_ctrl_sva (
	input logic clk,
	input logic rst,
	input logic slv_enable,
	input logic load_data,
	input bec_field_pkg::slot_t load_status,
	input logic ki
);
	import bec_field_pkg::*;

	localparam slot_t load_slots = slot_t'(`BEC_LOAD_SLOTS);

	// Number of assertion failures so far
	int fail_count = 0;

	// Streaming and execution are separate phases
	phase_excl: assert property (
		@(posedge clk) disable iff (rst)
		!(slv_enable && load_data)
	) else begin
		$error("slv_enable and load_data are high together");
		fail_count++;
	end

	slot_range: assert property (
		@(posedge clk) disable iff (rst)
		load_status < load_slots
	) else begin
		$error("load_status left the slot range");
		fail_count++;
	end

	// Key bits only go out while the coprocessor runs
	ki_quiet: assert property (
		@(posedge clk) disable iff (rst)
		!slv_enable |-> !ki
	) else begin
		$error("ki is high while slv_enable is low");
		fail_count++;
	end

endmodule

//--- tb/bec_ctrl_tb.sv
`timescale 1ns/10ps
`include "bec_consts.svh"

module bec_ctrl_tb;
	import bec_field_pkg::*;

	localparam word_t nop_word = 32'hFFFF_FFFF;
	localparam int num_runs = 2;
	// Idle, enter, 49 load words, start, 12 reads, finish, idle
	localparam int entries_per_run = 2 + 7 * 7 + 1 + `BEC_COLLECT_SLOTS + 2;
	localparam int cycle_limit = 4 * num_runs *
		(entries_per_run + `BEC_LOAD_SLOTS + `BEC_COLLECT_SLOTS + 40);

	localparam logic [1:0] chk_none = 2'd0;
	localparam logic [1:0] chk_value = 2'd1;
	localparam logic [1:0] chk_status = 2'd2;
	localparam logic [1:0] ph_none = 2'd0;
	localparam logic [1:0] ph_read = 2'd1;

	typedef struct packed {
		word_t cmd;
		word_t expect_word;
		logic [1:0] check_kind;
		logic [1:0] wait_code;
	} stim_entry_t;

	logic clk = 1'b0;
	logic rst;
	word_t la_data_in;
	logic next_key;
	logic slv_done;
	word_t data_in;
	word_t la_data_out;
	logic slv_enable;
	logic load_data;
	slot_t load_status;
	word_t data_out;
	logic ki;

	stim_entry_t stim_table[$];
	field_t exp_op [7];
	field_t exp_key;
	field_t res_w;
	field_t res_z;
	int err_count = 0;
	int check_count = 0;
	int load_cycles = 0;
	int en_count = 0;
	int exec_left = 0;
	int collect_left = 0;
	int cycle_cnt = 0;
	logic collect_done = 1'b0;

	bec_ctrl_top dut0 (
		.clk(clk),
		.rst(rst),
		.la_data_in(la_data_in),
		.next_key(next_key),
		.slv_done(slv_done),
		.data_in(data_in),
		.la_data_out(la_data_out),
		.slv_enable(slv_enable),
		.load_data(load_data),
		.load_status(load_status),
		.data_out(data_out),
		.ki(ki)
	);

	bind bec_ctrl_top bec_ctrl_sva sva0 (
		.clk(clk),
		.rst(rst),
		.slv_enable(slv_enable),
		.load_data(load_data),
		.load_status(load_status),
		.ki(ki)
	);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			err_count++;
			$display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	function automatic field_t rand_field();
		logic [6*`BEC_WORD_W-1:0] r;
		for (int i = 0; i < 6; i++) begin
			r[32*i +: 32] = $urandom;
		end
		return r[`BEC_FIELD_W-1:0];
	endfunction

	// Word k of a field zero-extended to 192 bits
	function automatic word_t coord_word(input field_t f, input int k);
		logic [6*`BEC_WORD_W-1:0] ext;
		ext = {29'b0, f};
		return ext[32*k +: 32];
	endfunction

	function automatic word_t load_word(input field_t f, input int op, input int c);
		logic [`BEC_CHUNK_W-1:0] p;
		if (c == 6) begin
			p = {19'b0, f[6:0]};
		end else begin
			p = f[`BEC_FIELD_W - 1 - `BEC_CHUNK_W * c -: `BEC_CHUNK_W];
		end
		return {3'(op), 3'(c), p};
	endfunction

	// Tag N+1 over a 28-bit chunk taken from the top of the result
	function automatic word_t read_word(input int n);
		field_t f;
		int k;
		logic [27:0] c;
		f = (n < 6) ? res_w : res_z;
		k = n % 6;
		if (k == 5) begin
			c = {5'b0, f[22:0]};
		end else begin
			c = f[`BEC_FIELD_W - 1 - 28 * k -: 28];
		end
		return {4'(n + 1), c};
	endfunction

	function automatic word_t result_word(input slot_t s);
		field_t f;
		int k;
		word_t w;
		f = (s < 6) ? res_w : res_z;
		k = (s < 6) ? int'(s) : int'(s) - 6;
		w = coord_word(f, k);
		// Noise above bit 2 of the top word
		if (k == 5) begin
			w[31:3] = 29'($urandom);
		end
		return w;
	endfunction

	task automatic add_entry(input word_t cmd, input word_t exp, input logic [1:0] kind,
			input logic [1:0] ph);
		stim_entry_t e;
		e.cmd = cmd;
		e.expect_word = exp;
		e.check_kind = kind;
		e.wait_code = ph;
		stim_table.push_back(e);
	endtask

	task automatic build_run_table();
		word_t w;
		stim_table.delete();
		for (int op = 0; op < 7; op++) begin
			exp_op[op] = rand_field();
		end
		res_w = rand_field();
		res_z = rand_field();
		en_count = 0;
		load_cycles = 0;
		collect_done = 1'b0;
		add_entry(nop_word, '0, chk_value, ph_none);
		add_entry({`BEC_CMD_ENTER, 16'h0000}, '0, chk_value, ph_none);
		for (int op = 0; op < 7; op++) begin
			for (int c = 0; c < 7; c++) begin
				w = load_word(exp_op[op], op, c);
				// A load word must never look like the enter code
				if (w[31:16] == `BEC_CMD_ENTER) begin
					exp_op[op][`BEC_FIELD_W - 1 - `BEC_CHUNK_W * c] ^= 1'b1;
					w = load_word(exp_op[op], op, c);
				end
				add_entry(w, '0, chk_value, ph_none);
			end
		end
		exp_key = exp_op[6];
		add_entry({`BEC_CMD_START, 16'h0000}, `BEC_BUSY_WORD, chk_value, ph_read);
		for (int n = 0; n < `BEC_COLLECT_SLOTS; n++) begin
			add_entry({12'h000, 4'(n), 16'h0000}, read_word(n), chk_value, ph_none);
		end
		add_entry(`BEC_CMD_FINISH, '0, chk_status, ph_none);
		add_entry(nop_word, '0, chk_value, ph_none);
	endtask

	// Called just after a rising edge, returns just after the edge that samples the word
	task automatic apply_entry(input stim_entry_t e);
		la_data_in = e.cmd;
		@(posedge clk);
		#1;
		la_data_in = nop_word;
		case (e.check_kind)
			chk_value: check_value("la_data_out", la_data_out, e.expect_word);
			chk_status: check_value("la_data_out", la_data_out,
				`BEC_STATUS_BASE ^ word_t'(en_count));
			default: ;
		endcase
		if (e.wait_code == ph_read) begin
			while (!collect_done) begin
				@(negedge clk);
			end
			collect_done = 1'b0;
			@(posedge clk);
			#1;
		end
	endtask

	// Coprocessor model, drive side
	always @(posedge clk) begin : coproc_drive
		#1;
		slv_done = 1'b0;
		data_in = '0;
		next_key = ($urandom % 2) != 0;
		if (slv_enable) begin
			if (exec_left == 0) begin
				exec_left = 5 + ($urandom % 36);
			end
			exec_left = exec_left - 1;
			if (exec_left == 0) begin
				slv_done = 1'b1;
				collect_left = `BEC_COLLECT_SLOTS;
			end
		end else if (collect_left != 0) begin
			data_in = result_word(load_status);
			collect_left = collect_left - 1;
			if (collect_left == 0) begin
				collect_done = 1'b1;
			end
		end
	end

	// Coprocessor model, observe side at mid cycle
	always @(negedge clk) begin : coproc_monitor
		word_t exp_word;
		if (!rst) begin
			if (load_data) begin
				check_value("load_status", 32'(load_status), load_cycles);
				exp_word = '0;
				if (load_status[2:0] < 3'd6) begin
					exp_word = coord_word(exp_op[load_status[5:3]], int'(load_status[2:0]));
				end
				check_value("data_out", data_out, exp_word);
				load_cycles++;
			end else begin
				check_value("data_out", data_out, '0);
			end
			if (slv_enable) begin
				check_value("ki", 32'(ki), 32'(exp_key[0]));
				if (next_key) begin
					exp_key = {exp_key[0], exp_key[`BEC_FIELD_W-1:1]};
				end
				if (!slv_done) begin
					en_count++;
				end
			end
			if (load_data || slv_enable) begin
				check_value("la_data_out", la_data_out, `BEC_BUSY_WORD);
			end
		end
	end

	initial begin : watchdog
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Checks run: %0d, errors: %0d, assertion failures: %0d",
			check_count, err_count, dut0.sva0.fail_count);
		$display("Test failures found");
		$finish;
	end

	initial begin : main_seq
		int seed_init;
		seed_init = $urandom(38);
		rst = 1'b1;
		la_data_in = nop_word;
		next_key = 1'b0;
		slv_done = 1'b0;
		data_in = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		check_value("la_data_out", la_data_out, '0);
		check_value("slv_enable", 32'(slv_enable), '0);
		check_value("load_data", 32'(load_data), '0);
		check_value("load_status", 32'(load_status), '0);
		check_value("ki", 32'(ki), '0);
		for (int run = 0; run < num_runs; run++) begin
			build_run_table();
			foreach (stim_table[i]) begin
				apply_entry(stim_table[i]);
			end
			check_value("load_data cycles", load_cycles, `BEC_LOAD_SLOTS);
		end
		$display("Checks run: %0d, errors: %0d, assertion failures: %0d",
			check_count, err_count, dut0.sva0.fail_count);
		if ((err_count == 0) && (dut0.sva0.fail_count == 0)) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
